// File: udp_regs_pkg.sv
`default_nettype none

package udp_regs_pkg;

    typedef logic [31:0] reg_data_t;
    typedef logic [5:0]  reg_addr_t;

    // Byte addresses of the configuration registers
    typedef enum reg_addr_t {
        REG_SENT_COUNT = 6'h00,  // Read only
        REG_TIMER      = 6'h04,  // Read only
        REG_DELAY      = 6'h08,
        REG_DST_MAC_LO = 6'h0C,  // Staged until the HI write
        REG_DST_MAC_HI = 6'h10,
        REG_SRC_IP     = 6'h14,
        REG_DST_IP     = 6'h18,
        REG_SRC_PORT   = 6'h1C,
        REG_DST_PORT   = 6'h20
    } reg_addr_e;

    // Reset defaults
    localparam reg_data_t   DEF_DELAY   = 32'd10_000_000;
    localparam logic [47:0] DEF_DST_MAC = 48'hFFFF_FFFF_FFFF;  // Broadcast
    localparam reg_data_t   DEF_SRC_IP  = 32'hC0A8_0463;        // 192.168.4.99
    localparam reg_data_t   DEF_DST_IP  = 32'hC0A8_0401;        // 192.168.4.1
    localparam logic [15:0] DEF_PORT    = 16'hEAE5;             // 60133

endpackage

`default_nettype wire

// File: udp_frame_pkg.sv
`default_nettype none

package udp_frame_pkg;

    // Frame geometry
    localparam int PAYLOAD_WORDS = 64;
    localparam int HDR_BYTES     = 42;
    localparam int FRAME_BYTES   = HDR_BYTES + 2 * PAYLOAD_WORDS;
    localparam int BEAT_BYTES    = 8;
    localparam int NUM_BEATS     = (FRAME_BYTES + BEAT_BYTES - 1) / BEAT_BYTES;

    // Bytes used in the final beat or zero when it is full
    localparam int LAST_BYTES = FRAME_BYTES % BEAT_BYTES;

    // Stream beat types
    typedef logic [63:0] axis_data_t;
    typedef logic [7:0]  axis_keep_t;
    typedef logic [4:0]  beat_idx_t;

    localparam axis_keep_t LAST_KEEP =
        (LAST_BYTES == 0) ? 8'hFF : 8'((1 << LAST_BYTES) - 1);

    // Header bytes with index 0 first on the wire
    typedef logic [0:HDR_BYTES-1][7:0] hdr_bytes_t;

    typedef logic [47:0] mac_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;

    // Fixed header fields
    localparam mac_t        SRC_MAC       = 48'h001A_2B3C_4D5E;
    localparam logic [15:0] ETH_TYPE_IPV4 = 16'h0800;
    localparam logic [7:0]  IP_VER_IHL    = 8'h45;      // IPv4 with a five-word header
    localparam logic [15:0] IP_ID         = 16'd1;
    localparam logic [15:0] IP_FLAGS      = 16'h4000;   // Don't fragment
    localparam logic [7:0]  IP_TTL        = 8'd255;
    localparam logic [7:0]  IP_PROTO_UDP  = 8'd17;

    // Lengths follow from the payload size
    localparam logic [15:0] IP_TOTAL_LEN = 16'(28 + 2 * PAYLOAD_WORDS);
    localparam logic [15:0] UDP_LEN      = 16'(8 + 2 * PAYLOAD_WORDS);

    // Transmit FSM
    typedef enum logic {
        TX_IDLE,
        TX_SEND
    } tx_state_e;

endpackage

`default_nettype wire

// File: udp_cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none

module udp_cfg_regs
    import udp_regs_pkg::*;
    import udp_frame_pkg::*;
(
    input  wire logic      m00_axis_aclk,
    input  wire logic      m00_axis_aresetn,
    // Write channel
    input  wire logic      wr_valid,
    input  wire reg_addr_t wr_addr,
    input  wire reg_data_t wr_data,
    output logic           wr_ready,
    // Read request and response
    input  wire logic      rd_valid,
    input  wire reg_addr_t rd_addr,
    output logic           rd_ready,
    output logic           rdata_valid,
    output reg_data_t      rdata,
    input  wire logic      rdata_ready,
    // Status from the transmitter
    input  wire reg_data_t sent_count,
    input  wire reg_data_t timer_count,
    // Configuration outputs
    output reg_data_t      pkt_delay,
    output mac_t           dst_mac,
    output ip_addr_t       src_ip,
    output ip_addr_t       dst_ip,
    output udp_port_t      src_port,
    output udp_port_t      dst_port
);

    logic [31:0] mac_lo_stage;  // Low four MAC bytes awaiting the HI write
    reg_data_t   rd_value;

    assign wr_ready = 1'b1;         // Writes always complete in one cycle
    assign rd_ready = ~rdata_valid; // One response outstanding at most

    always_ff @(posedge m00_axis_aclk or negedge m00_axis_aresetn) begin
        if (!m00_axis_aresetn) begin
            pkt_delay    <= DEF_DELAY;
            dst_mac      <= DEF_DST_MAC;
            mac_lo_stage <= DEF_DST_MAC[31:0];
            src_ip       <= DEF_SRC_IP;
            dst_ip       <= DEF_DST_IP;
            src_port     <= DEF_PORT;
            dst_port     <= DEF_PORT;
        end else if (wr_valid && wr_ready) begin
            case (reg_addr_e'(wr_addr))
                REG_DELAY:      pkt_delay    <= wr_data;
                REG_DST_MAC_LO: mac_lo_stage <= wr_data;
                REG_DST_MAC_HI: dst_mac      <= {wr_data[15:0], mac_lo_stage};
                REG_SRC_IP:     src_ip       <= wr_data;
                REG_DST_IP:     dst_ip       <= wr_data;
                REG_SRC_PORT:   src_port     <= wr_data[15:0];
                REG_DST_PORT:   dst_port     <= wr_data[15:0];
                default: ;      // Status registers ignore writes
            endcase
        end
    end

    // Read mux
    always_comb begin
        case (reg_addr_e'(rd_addr))
            REG_SENT_COUNT: rd_value = sent_count;
            REG_TIMER:      rd_value = timer_count;
            REG_DELAY:      rd_value = pkt_delay;
            REG_DST_MAC_LO: rd_value = dst_mac[31:0];       // Committed value
            REG_DST_MAC_HI: rd_value = {16'h0000, dst_mac[47:32]};
            REG_SRC_IP:     rd_value = src_ip;
            REG_DST_IP:     rd_value = dst_ip;
            REG_SRC_PORT:   rd_value = {16'h0000, src_port};
            REG_DST_PORT:   rd_value = {16'h0000, dst_port};
            default:        rd_value = '0;
        endcase
    end

    always_ff @(posedge m00_axis_aclk or negedge m00_axis_aresetn) begin
        if (!m00_axis_aresetn) begin
            rdata_valid <= 1'b0;
        end else if (rd_valid && rd_ready) begin
            rdata_valid <= 1'b1;
        end else if (rdata_ready) begin
            rdata_valid <= 1'b0;  // Response taken
        end
    end

    // Response data held until accepted
    always_ff @(posedge m00_axis_aclk) begin
        if (rd_valid && rd_ready) begin
            rdata <= rd_value;
        end
    end

endmodule

`default_nettype wire

// File: udp_header_gen.sv
`timescale 1ns/1ps
`default_nettype none

module udp_header_gen
    import udp_frame_pkg::*;
(
    input  wire logic      m00_axis_aclk,
    input  wire logic      m00_axis_aresetn,
    input  wire logic      frame_start,
    input  wire mac_t      dst_mac,
    input  wire ip_addr_t  src_ip,
    input  wire ip_addr_t  dst_ip,
    input  wire udp_port_t src_port,
    input  wire udp_port_t dst_port,
    output hdr_bytes_t     hdr
);

    logic [15:0] ip_csum;
    hdr_bytes_t  hdr_next;

    // Ones'-complement sum over the IPv4 header with the checksum word zero
    function automatic logic [15:0] ip_checksum(input ip_addr_t sip, input ip_addr_t dip);
        logic [19:0] sum;
        sum = 20'({IP_VER_IHL, 8'h00})
            + 20'(IP_TOTAL_LEN)
            + 20'(IP_ID)
            + 20'(IP_FLAGS)
            + 20'({IP_TTL, IP_PROTO_UDP})
            + 20'(sip[31:16]) + 20'(sip[15:0])
            + 20'(dip[31:16]) + 20'(dip[15:0]);
        // Two folds clear every carry of a ten-word sum
        for (int i = 0; i < 2; i++) begin
            sum = 20'(sum[15:0]) + 20'(sum[19:16]);
        end
        return ~sum[15:0];
    endfunction

    always_comb begin
        ip_csum  = ip_checksum(src_ip, dst_ip);
        hdr_next = {
            dst_mac, SRC_MAC, ETH_TYPE_IPV4,                  // Ethernet
            IP_VER_IHL, 8'h00, IP_TOTAL_LEN,                  // IPv4
            IP_ID, IP_FLAGS,
            IP_TTL, IP_PROTO_UDP, ip_csum,
            src_ip, dst_ip,
            src_port, dst_port, UDP_LEN, 16'h0000             // UDP without checksum
        };
    end

    // Snapshot at frame start so register writes never tear a frame
    always_ff @(posedge m00_axis_aclk or negedge m00_axis_aresetn) begin
        if (!m00_axis_aresetn) begin
            hdr <= '0;
        end else if (frame_start) begin
            hdr <= hdr_next;
        end
    end

endmodule

`default_nettype wire

// File: frame_beat_gen.sv
`timescale 1ns/1ps
`default_nettype none

module frame_beat_gen
    import udp_frame_pkg::*;
(
    input  wire hdr_bytes_t hdr,
    input  wire beat_idx_t  beat_idx,
    output axis_data_t      beat_data,
    output axis_keep_t      beat_keep,
    output logic            beat_last
);

    // Byte k of the frame
    function automatic logic [7:0] frame_byte(input hdr_bytes_t h, input logic [7:0] k);
        logic [7:0]  p;
        logic [6:0]  j;
        logic [15:0] word;
        p = 8'(k - 8'(HDR_BYTES));  // Offset into payload
        j = p[7:1];
        if (j[0]) begin
            word = 16'(255 - 32'(j >> 1));  // Odd word counts down from 255
        end else begin
            word = 16'(j >> 1);
        end
        if (k < 8'(HDR_BYTES)) begin
            return h[k];
        end else if (k < 8'(FRAME_BYTES)) begin
            return p[0] ? word[15:8] : word[7:0];  // Low byte first
        end else begin
            return 8'h00;  // Past the end of the frame
        end
    endfunction

    always_comb begin
        for (int l = 0; l < BEAT_BYTES; l++) begin
            beat_data[l*8 +: 8] = frame_byte(hdr, {beat_idx, 3'(l)});
        end
    end

    assign beat_last = (beat_idx == beat_idx_t'(NUM_BEATS - 1));
    assign beat_keep = beat_last ? LAST_KEEP : '1;

endmodule

`default_nettype wire

// File: axis_frame_tx.sv
`timescale 1ns/1ps
`default_nettype none

module axis_frame_tx
    import udp_frame_pkg::*;
(
    input  wire logic        m00_axis_aclk,
    input  wire logic        m00_axis_aresetn,
    input  wire logic [31:0] pkt_delay,
    // Beat contents for the current index
    input  wire axis_data_t  beat_data,
    input  wire axis_keep_t  beat_keep,
    input  wire logic        beat_last,
    output logic             frame_start,
    output beat_idx_t        beat_idx,
    output logic [31:0]      sent_count,
    output logic [31:0]      timer_count,
    // AXI4-Stream master
    output logic             m00_axis_tvalid,
    output axis_data_t       m00_axis_tdata,
    output axis_keep_t       m00_axis_tkeep,
    output logic             m00_axis_tlast,
    input  wire logic        m00_axis_tready
);

    tx_state_e state;
    logic      start_pend;  // Timer expired and frame not yet started
    logic      expire;
    logic      beat_ack;

    assign expire      = (pkt_delay != '0) && (timer_count == pkt_delay);
    assign frame_start = start_pend && (state == TX_IDLE);
    assign beat_ack    = m00_axis_tvalid && m00_axis_tready;

    // Interval timer
    always_ff @(posedge m00_axis_aclk or negedge m00_axis_aresetn) begin
        if (!m00_axis_aresetn) begin
            timer_count <= '0;
            start_pend  <= 1'b0;
        end else begin
            timer_count <= expire ? '0 : timer_count + 32'd1;
            start_pend  <= expire || (start_pend && !frame_start);
        end
    end

    // Transmit FSM and beat counter
    always_ff @(posedge m00_axis_aclk or negedge m00_axis_aresetn) begin
        if (!m00_axis_aresetn) begin
            state      <= TX_IDLE;
            beat_idx   <= '0;
            sent_count <= '0;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (frame_start) begin
                        state    <= TX_SEND;
                        beat_idx <= '0;
                    end
                end
                TX_SEND: begin
                    if (beat_ack) begin
                        if (beat_idx == '0) begin
                            sent_count <= sent_count + 32'd1;  // Counted on the first beat
                        end
                        if (beat_last) begin
                            state    <= TX_IDLE;
                            beat_idx <= '0;
                        end else begin
                            beat_idx <= beat_idx + 1'b1;
                        end
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // Index and header hold while stalled so the beat stays steady
    assign m00_axis_tvalid = (state == TX_SEND);
    assign m00_axis_tdata  = m00_axis_tvalid ? beat_data : '0;
    assign m00_axis_tkeep  = m00_axis_tvalid ? beat_keep : '0;
    assign m00_axis_tlast  = m00_axis_tvalid && beat_last;

endmodule

`default_nettype wire

// File: udp_stream_top.sv
`timescale 1ns/1ps
`default_nettype none

module udp_stream_top
    import udp_regs_pkg::*;
    import udp_frame_pkg::*;
(
    input  wire logic      m00_axis_aclk,
    input  wire logic      m00_axis_aresetn,
    // Configuration register port
    input  wire logic      wr_valid,
    input  wire reg_addr_t wr_addr,
    input  wire reg_data_t wr_data,
    output logic           wr_ready,
    input  wire logic      rd_valid,
    input  wire reg_addr_t rd_addr,
    output logic           rd_ready,
    output logic           rdata_valid,
    output reg_data_t      rdata,
    input  wire logic      rdata_ready,
    // AXI4-Stream master
    output logic           m00_axis_tvalid,
    output axis_data_t     m00_axis_tdata,
    output axis_keep_t     m00_axis_tkeep,
    output logic           m00_axis_tlast,
    input  wire logic      m00_axis_tready
);

    reg_data_t  pkt_delay;
    reg_data_t  sent_count;
    reg_data_t  timer_count;
    mac_t       dst_mac;
    ip_addr_t   src_ip;
    ip_addr_t   dst_ip;
    udp_port_t  src_port;
    udp_port_t  dst_port;
    logic       frame_start;
    hdr_bytes_t hdr;
    beat_idx_t  beat_idx;
    axis_data_t beat_data;
    axis_keep_t beat_keep;
    logic       beat_last;

    udp_cfg_regs u_cfg_regs (
        .m00_axis_aclk, .m00_axis_aresetn,
        .wr_valid, .wr_addr, .wr_data, .wr_ready,
        .rd_valid, .rd_addr, .rd_ready,
        .rdata_valid, .rdata, .rdata_ready,
        .sent_count, .timer_count,
        .pkt_delay, .dst_mac, .src_ip, .dst_ip, .src_port, .dst_port
    );

    udp_header_gen u_header_gen (
        .m00_axis_aclk, .m00_axis_aresetn, .frame_start,
        .dst_mac, .src_ip, .dst_ip, .src_port, .dst_port,
        .hdr
    );

    frame_beat_gen u_beat_gen (
        .hdr, .beat_idx, .beat_data, .beat_keep, .beat_last
    );

    axis_frame_tx u_frame_tx (
        .m00_axis_aclk, .m00_axis_aresetn, .pkt_delay,
        .beat_data, .beat_keep, .beat_last,
        .frame_start, .beat_idx, .sent_count, .timer_count,
        .m00_axis_tvalid, .m00_axis_tdata, .m00_axis_tkeep, .m00_axis_tlast,
        .m00_axis_tready
    );

endmodule

`default_nettype wire

// File: tb_udp_stream.sv
`timescale 1ns/1ps
`default_nettype none

module tb_udp_stream
    import udp_regs_pkg::*;
    import udp_frame_pkg::*;
();

    localparam int SEED         = 32'h132f;
    localparam int TEST_DELAY   = 300;
    localparam int NUM_FRAMES   = 4;     // Frames over tests 3 to 5
    localparam int IDLE_CYCLES  = 1000;  // Quiet span of the zero-delay test
    localparam int DRAIN_CYCLES = 100;
    localparam int REG_WAIT     = 16;
    localparam int FRAME_LIMIT  = TEST_DELAY + NUM_BEATS * 4 + 32;
    localparam int WATCHDOG_CYCLES =
        NUM_FRAMES * (TEST_DELAY + NUM_BEATS * 4) + IDLE_CYCLES + 2000;

    logic       m00_axis_aclk = 1'b0;
    logic       m00_axis_aresetn;
    logic       wr_valid;
    reg_addr_t  wr_addr;
    reg_data_t  wr_data;
    logic       wr_ready;
    logic       rd_valid;
    reg_addr_t  rd_addr;
    logic       rd_ready;
    logic       rdata_valid;
    reg_data_t  rdata;
    logic       rdata_ready;
    logic       m00_axis_tvalid;
    axis_data_t m00_axis_tdata;
    axis_keep_t m00_axis_tkeep;
    logic       m00_axis_tlast;
    logic       m00_axis_tready;

    int         value_errors = 0;
    int         other_errors = 0;
    logic [7:0] exp_frame [FRAME_BYTES];  // Reference frame in wire order

    // Configuration currently held by the DUT
    mac_t       cfg_mac;
    ip_addr_t   cfg_sip;
    ip_addr_t   cfg_dip;
    udp_port_t  cfg_sport;
    udp_port_t  cfg_dport;

    udp_stream_top DUT (
        .m00_axis_aclk, .m00_axis_aresetn,
        .wr_valid, .wr_addr, .wr_data, .wr_ready,
        .rd_valid, .rd_addr, .rd_ready,
        .rdata_valid, .rdata, .rdata_ready,
        .m00_axis_tvalid, .m00_axis_tdata, .m00_axis_tkeep, .m00_axis_tlast,
        .m00_axis_tready
    );

    always #20 m00_axis_aclk = ~m00_axis_aclk;

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge m00_axis_aclk);
        $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

    task automatic check_reg(input string name, input reg_data_t got, input reg_data_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("[FAIL] %s: got 0x%08h expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            value_errors++;
            $display("[FAIL] %s: got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic check_beat(input int beat, input axis_data_t got_data,
                              input axis_keep_t got_keep, input logic got_last,
                              input axis_data_t exp_data, input axis_keep_t exp_keep,
                              input logic exp_last);
        if (got_data !== exp_data) begin
            value_errors++;
            $display("[FAIL] m00_axis_tdata beat %0d: got 0x%016h expected 0x%016h",
                     beat, got_data, exp_data);
        end
        if (got_keep !== exp_keep) begin
            value_errors++;
            $display("[FAIL] m00_axis_tkeep beat %0d: got 0x%02h expected 0x%02h",
                     beat, got_keep, exp_keep);
        end
        if (got_last !== exp_last) begin
            value_errors++;
            $display("[FAIL] m00_axis_tlast beat %0d: got 0x%0h expected 0x%0h",
                     beat, got_last, exp_last);
        end
    endtask

    task automatic write_reg(input reg_addr_e addr, input reg_data_t data);
        int n;
        @(posedge m00_axis_aclk);
        wr_valid <= 1'b1;
        wr_addr  <= addr;
        wr_data  <= data;
        for (n = 0; n < REG_WAIT; n++) begin
            @(negedge m00_axis_aclk);
            if (wr_ready) break;
        end
        if (n == REG_WAIT) begin
            other_errors++;
            $display("Write to address 0x%02h was never accepted", addr);
        end
        @(posedge m00_axis_aclk);
        wr_valid <= 1'b0;
    endtask

    task automatic read_reg(input reg_addr_e addr, output reg_data_t data);
        int n;
        data = '0;
        @(posedge m00_axis_aclk);
        rd_valid    <= 1'b1;
        rd_addr     <= addr;
        rdata_ready <= 1'b1;
        for (n = 0; n < REG_WAIT; n++) begin
            @(negedge m00_axis_aclk);
            if (rd_ready) break;
        end
        if (n == REG_WAIT) begin
            other_errors++;
            $display("Read request for address 0x%02h was never accepted", addr);
        end
        @(posedge m00_axis_aclk);
        rd_valid <= 1'b0;
        for (n = 0; n < REG_WAIT; n++) begin
            @(negedge m00_axis_aclk);
            if (rdata_valid) break;
        end
        if (n == REG_WAIT) begin
            other_errors++;
            $display("No read response for address 0x%02h", addr);
        end else begin
            data = rdata;
        end
        @(posedge m00_axis_aclk);  // Response taken on this edge
        rdata_ready <= 1'b0;
    endtask

    task automatic read_and_check(input reg_addr_e addr, input string name,
                                  input reg_data_t exp);
        reg_data_t got;
        read_reg(addr, got);
        check_reg(name, got, exp);
    endtask

    // Expected frame from the current configuration
    task automatic build_frame();
        int unsigned sum;
        logic [15:0] csum;
        logic [15:0] word;
        int          total_len;
        int          udp_len;
        total_len = 28 + 2 * PAYLOAD_WORDS;
        udp_len   = 8 + 2 * PAYLOAD_WORDS;
        for (int i = 0; i < 6; i++) begin
            exp_frame[i]     = cfg_mac[47 - 8 * i -: 8];
            exp_frame[6 + i] = 8'h00 + 8'(i * 17 + (i > 0 ? 9 : 0));  // 00 1A 2B 3C 4D 5E
        end
        exp_frame[12] = 8'h08;
        exp_frame[13] = 8'h00;
        exp_frame[14] = 8'h45;
        exp_frame[15] = 8'h00;
        exp_frame[16] = 8'(total_len >> 8);
        exp_frame[17] = 8'(total_len);
        exp_frame[18] = 8'h00;  // ID 1
        exp_frame[19] = 8'h01;
        exp_frame[20] = 8'h40;  // DF set
        exp_frame[21] = 8'h00;
        exp_frame[22] = 8'hFF;
        exp_frame[23] = 8'd17;
        exp_frame[24] = 8'h00;
        exp_frame[25] = 8'h00;
        for (int i = 0; i < 4; i++) begin
            exp_frame[26 + i] = cfg_sip[31 - 8 * i -: 8];
            exp_frame[30 + i] = cfg_dip[31 - 8 * i -: 8];
        end
        exp_frame[34] = cfg_sport[15:8];
        exp_frame[35] = cfg_sport[7:0];
        exp_frame[36] = cfg_dport[15:8];
        exp_frame[37] = cfg_dport[7:0];
        exp_frame[38] = 8'(udp_len >> 8);
        exp_frame[39] = 8'(udp_len);
        exp_frame[40] = 8'h00;
        exp_frame[41] = 8'h00;
        sum = 0;
        for (int i = 0; i < 10; i++) begin
            sum += {exp_frame[14 + 2 * i], exp_frame[15 + 2 * i]};
        end
        while ((sum >> 16) != 0) begin
            sum = (sum & 32'hFFFF) + (sum >> 16);
        end
        csum = ~sum[15:0];
        exp_frame[24] = csum[15:8];
        exp_frame[25] = csum[7:0];
        for (int j = 0; j < PAYLOAD_WORDS; j++) begin
            word = (j % 2 == 0) ? 16'(j / 2) : 16'(255 - (j - 1) / 2);
            exp_frame[HDR_BYTES + 2 * j]     = word[7:0];   // Low byte first
            exp_frame[HDR_BYTES + 2 * j + 1] = word[15:8];
        end
    endtask

    task automatic expected_beat(input int beat, output axis_data_t data,
                                 output axis_keep_t keep, output logic last);
        int k;
        data = '0;
        keep = '0;
        for (int l = 0; l < BEAT_BYTES; l++) begin
            k = beat * BEAT_BYTES + l;
            if (k < FRAME_BYTES) begin
                data[l * 8 +: 8] = exp_frame[k];
                keep[l] = 1'b1;
            end
        end
        last = (beat == NUM_BEATS - 1);
    endtask

    // Collect one frame and compare every valid cycle with the model
    task automatic receive_frame(input bit random_ready);
        int         beat;
        int         waited;
        bit         started;
        bit         stalled;
        axis_data_t ed;
        axis_keep_t ek;
        logic       el;
        axis_data_t held_data;
        axis_keep_t held_keep;
        logic       held_last;
        beat    = 0;
        waited  = 0;
        started = 0;
        stalled = 0;
        while (beat < NUM_BEATS && waited < FRAME_LIMIT) begin
            @(posedge m00_axis_aclk);
            m00_axis_tready <= random_ready ? (($urandom % 4) != 0) : 1'b1;
            @(negedge m00_axis_aclk);
            waited++;
            if (m00_axis_tvalid) begin
                started = 1;
                expected_beat(beat, ed, ek, el);
                check_beat(beat, m00_axis_tdata, m00_axis_tkeep, m00_axis_tlast, ed, ek, el);
                if (stalled) begin  // Must match the stalled cycle
                    check_beat(beat, m00_axis_tdata, m00_axis_tkeep, m00_axis_tlast,
                               held_data, held_keep, held_last);
                end
                stalled   = !m00_axis_tready;
                held_data = m00_axis_tdata;
                held_keep = m00_axis_tkeep;
                held_last = m00_axis_tlast;
                if (m00_axis_tready) beat++;
            end else if (started) begin
                other_errors++;
                $display("tvalid dropped in the middle of a frame at beat %0d", beat);
            end
        end
        if (beat < NUM_BEATS) begin
            other_errors++;
            $display("No complete frame within %0d cycles, %0d beats seen", FRAME_LIMIT, beat);
        end
    endtask

    // Stop the timer and let any started frame finish
    task automatic pause_frames();
        write_reg(REG_DELAY, '0);
        @(posedge m00_axis_aclk);
        m00_axis_tready <= 1'b1;
        repeat (DRAIN_CYCLES) @(posedge m00_axis_aclk);
    endtask

    task automatic test_reset_defaults();
        check_flag("m00_axis_tvalid", m00_axis_tvalid, 1'b0);
        check_flag("m00_axis_tlast", m00_axis_tlast, 1'b0);
        check_flag("rdata_valid", rdata_valid, 1'b0);
        check_flag("wr_ready", wr_ready, 1'b1);
        check_flag("rd_ready", rd_ready, 1'b1);
        read_and_check(REG_DELAY, "REG_DELAY", DEF_DELAY);
        read_and_check(REG_DST_MAC_LO, "REG_DST_MAC_LO", DEF_DST_MAC[31:0]);
        read_and_check(REG_DST_MAC_HI, "REG_DST_MAC_HI", {16'h0000, DEF_DST_MAC[47:32]});
        read_and_check(REG_SRC_IP, "REG_SRC_IP", DEF_SRC_IP);
        read_and_check(REG_DST_IP, "REG_DST_IP", DEF_DST_IP);
        read_and_check(REG_SRC_PORT, "REG_SRC_PORT", {16'h0000, DEF_PORT});
        read_and_check(REG_DST_PORT, "REG_DST_PORT", {16'h0000, DEF_PORT});
        read_and_check(REG_SENT_COUNT, "REG_SENT_COUNT", '0);
    endtask

    task automatic test_reg_access();
        write_reg(REG_DELAY, 32'h0020_0000);  // Long enough that no frame starts
        read_and_check(REG_DELAY, "REG_DELAY", 32'h0020_0000);
        write_reg(REG_DST_MAC_LO, 32'h2233_4455);
        read_and_check(REG_DST_MAC_LO, "REG_DST_MAC_LO", DEF_DST_MAC[31:0]);
        write_reg(REG_DST_MAC_HI, 32'h0000_0211);
        cfg_mac = 48'h0211_2233_4455;
        read_and_check(REG_DST_MAC_LO, "REG_DST_MAC_LO", 32'h2233_4455);
        read_and_check(REG_DST_MAC_HI, "REG_DST_MAC_HI", 32'h0000_0211);
        cfg_sip   = 32'hC0A8_0A05;
        cfg_dip   = 32'hC0A8_0AFF;
        cfg_sport = 16'h1F90;
        cfg_dport = 16'h0BB8;
        write_reg(REG_SRC_IP, cfg_sip);
        write_reg(REG_DST_IP, cfg_dip);
        write_reg(REG_SRC_PORT, {16'h0000, cfg_sport});
        write_reg(REG_DST_PORT, {16'h0000, cfg_dport});
        read_and_check(REG_SRC_IP, "REG_SRC_IP", cfg_sip);
        read_and_check(REG_DST_IP, "REG_DST_IP", cfg_dip);
        read_and_check(REG_SRC_PORT, "REG_SRC_PORT", {16'h0000, cfg_sport});
        read_and_check(REG_DST_PORT, "REG_DST_PORT", {16'h0000, cfg_dport});
    endtask

    task automatic test_first_frame();
        build_frame();
        write_reg(REG_DELAY, TEST_DELAY);
        receive_frame(1'b0);
        read_and_check(REG_SENT_COUNT, "REG_SENT_COUNT", 32'd1);
    endtask

    task automatic test_new_header();
        pause_frames();
        cfg_mac   = 48'h0200_5E10_2030;
        cfg_sip   = 32'h0A00_0001;
        cfg_dip   = 32'h0A00_00FF;
        cfg_sport = 16'h1234;
        cfg_dport = 16'h4321;
        write_reg(REG_DST_MAC_LO, cfg_mac[31:0]);
        write_reg(REG_DST_MAC_HI, {16'h0000, cfg_mac[47:32]});
        write_reg(REG_SRC_IP, cfg_sip);
        write_reg(REG_DST_IP, cfg_dip);
        write_reg(REG_SRC_PORT, {16'h0000, cfg_sport});
        write_reg(REG_DST_PORT, {16'h0000, cfg_dport});
        build_frame();
        write_reg(REG_DELAY, TEST_DELAY);
        receive_frame(1'b0);
    endtask

    task automatic test_backpressure();
        reg_data_t base;
        pause_frames();
        read_reg(REG_SENT_COUNT, base);
        write_reg(REG_DELAY, TEST_DELAY);
        receive_frame(1'b1);
        receive_frame(1'b1);
        pause_frames();
        read_and_check(REG_SENT_COUNT, "REG_SENT_COUNT", base + 32'd2);
    endtask

    task automatic test_zero_delay();
        reg_data_t base;
        bit        seen;
        seen = 0;
        pause_frames();
        read_reg(REG_SENT_COUNT, base);
        repeat (IDLE_CYCLES) begin
            @(negedge m00_axis_aclk);
            if (m00_axis_tvalid && !seen) begin
                check_flag("m00_axis_tvalid", m00_axis_tvalid, 1'b0);
                seen = 1;
            end
        end
        read_and_check(REG_SENT_COUNT, "REG_SENT_COUNT", base);
    endtask

    initial begin
        void'($urandom(SEED));
        m00_axis_aresetn = 1'b0;
        wr_valid         = 1'b0;
        wr_addr          = '0;
        wr_data          = '0;
        rd_valid         = 1'b0;
        rd_addr          = '0;
        rdata_ready      = 1'b0;
        m00_axis_tready  = 1'b1;
        cfg_mac          = DEF_DST_MAC;
        cfg_sip          = DEF_SRC_IP;
        cfg_dip          = DEF_DST_IP;
        cfg_sport        = DEF_PORT;
        cfg_dport        = DEF_PORT;
        repeat (2) @(posedge m00_axis_aclk);
        m00_axis_aresetn <= 1'b1;
        @(negedge m00_axis_aclk);

        test_reset_defaults();
        test_reg_access();
        test_first_frame();
        test_new_header();
        test_backpressure();
        test_zero_delay();

        $display("Checks done: %0d value errors, %0d other errors", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
udp_regs_pkg.sv
udp_frame_pkg.sv
udp_cfg_regs.sv
udp_header_gen.sv
frame_beat_gen.sv
axis_frame_tx.sv
udp_stream_top.sv
tb_udp_stream.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the UDP stream testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_udp_stream \
    -f verilog.f -o sim_udp_stream

sim_out=$(./obj_dir/sim_udp_stream)
echo "$sim_out"

if echo "$sim_out" | grep -qx "TESTS PASSED"; then
    exit 0
fi
exit 1
